// ==== src/ndn_pkg.sv ====
// ##############################
// Widths, table size and frame layout shared by the link blocks
// Lengths stop at 63, so the last prefix bit never takes part in a match
// ##############################
`default_nettype none

package ndn_pkg;

    // Field widths on the wire
    localparam int PREFIX_W     = 64;
    localparam int LEN_W        = 6;
    localparam int DATA_W       = 32;
    localparam int HDR_W        = 8;

    // Prefix table geometry
    localparam int NUM_ENTRIES  = 4;
    localparam int IDX_W        = 2;

    // Reply frame lengths, start bit included
    localparam int HIT_FRAME_W  = 1 + HDR_W + PREFIX_W + DATA_W;
    localparam int MISS_FRAME_W = 1 + HDR_W;
    localparam int FRAME_CNT_W  = $clog2(HIT_FRAME_W + 1);

    // Decoder bit counter covers the longest field
    localparam int DEC_CNT_W    = $clog2(PREFIX_W);

    // Interest as seen by the table
    typedef struct packed {
        logic [LEN_W-1:0]    len;
        logic [PREFIX_W-1:0] prefix;
        logic                type_bit;
    } interest_t;

    // One loadable table entry
    typedef struct packed {
        logic                valid;
        logic [LEN_W-1:0]    len;
        logic [PREFIX_W-1:0] prefix;
        logic [DATA_W-1:0]   data;
    } table_entry_t;

    // Winner of one lookup, zero fields on a miss
    typedef struct packed {
        logic                hit;
        logic [LEN_W-1:0]    len;
        logic [PREFIX_W-1:0] prefix;
        logic [DATA_W-1:0]   data;
    } lookup_result_t;

endpackage

`default_nettype wire

// ==== src/ndn_frame_decoder.sv ====
// ##############################
// Receive side of the link, one rx bit per clk while cs is low
// Only interest frames (type 1) are passed on, data frames are swallowed
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_frame_decoder (
    input  wire                clk,
    input  wire                rst,
    input  wire                rx,
    input  wire                cs,
    output ndn_pkg::interest_t interest,
    output logic               interest_valid
);

    import ndn_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PFX
    } state_t;

    state_t               state_q;
    logic [DEC_CNT_W-1:0] bit_cnt_q;

    // Type and length only, the filler bit falls off the top
    logic [HDR_W-2:0]     hdr_q;
    logic [PREFIX_W-1:0]  pfx_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= ST_IDLE;
            bit_cnt_q      <= '0;
            interest_valid <= 1'b0;
        end else begin
            interest_valid <= 1'b0;
            if (cs) begin
                // Deselect abandons a partial frame
                state_q <= ST_IDLE;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        // Hunt for the low start bit
                        if (!rx) begin
                            state_q   <= ST_HDR;
                            bit_cnt_q <= DEC_CNT_W'(HDR_W - 1);
                        end
                    end
                    ST_HDR: begin
                        if (bit_cnt_q == '0) begin
                            state_q   <= ST_PFX;
                            bit_cnt_q <= DEC_CNT_W'(PREFIX_W - 1);
                        end else begin
                            bit_cnt_q <= bit_cnt_q - 1'b1;
                        end
                    end
                    ST_PFX: begin
                        if (bit_cnt_q == '0) begin
                            state_q        <= ST_IDLE;
                            // Strobe on the same edge as the last prefix bit
                            interest_valid <= hdr_q[HDR_W-2];
                        end else begin
                            bit_cnt_q <= bit_cnt_q - 1'b1;
                        end
                    end
                    default: state_q <= ST_IDLE;
                endcase
            end
        end
    end

    // Field shifters, MSB arrives first
    always_ff @(posedge clk) begin
        if (!cs && state_q == ST_HDR) begin
            hdr_q <= {hdr_q[HDR_W-3:0], rx};
        end
        if (!cs && state_q == ST_PFX) begin
            pfx_q <= {pfx_q[PREFIX_W-2:0], rx};
        end
    end

    // Held stable in the strobe cycle since the FSM is back in idle
    assign interest.len      = hdr_q[LEN_W-1:0];
    assign interest.prefix   = pfx_q;
    assign interest.type_bit = hdr_q[HDR_W-2];

endmodule

`default_nettype wire

// ==== src/ndn_prefix_table.sv ====
// ##############################
// Longest-prefix match over the loadable entries
// Result one clk after the interest, ties go to the lowest index
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_prefix_table (
    input  wire                     clk,
    input  wire                     rst,
    input  ndn_pkg::interest_t      interest,
    input  wire                     interest_valid,
    input  wire                     table_wr,
    input  wire [ndn_pkg::IDX_W-1:0] table_wr_index,
    input  ndn_pkg::table_entry_t   table_wr_entry,
    output ndn_pkg::lookup_result_t result,
    output logic                    result_valid
);

    import ndn_pkg::*;

    // Valid bits are the only state reset clears
    logic [NUM_ENTRIES-1:0] valid_q;
    table_entry_t           entry_q [NUM_ENTRIES];

    logic [NUM_ENTRIES-1:0] match;
    logic                   found;
    logic [IDX_W-1:0]       best_idx;
    logic [LEN_W-1:0]       best_len;

    // Top len bits set, len 0 gives an empty mask
    function automatic logic [PREFIX_W-1:0] len_mask(input logic [LEN_W-1:0] len);
        len_mask = ~({PREFIX_W{1'b1}} >> len);
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (table_wr) begin
            valid_q[table_wr_index] <= table_wr_entry.valid;
        end
    end

    // Entry payload, lookups in the write cycle still see the old value
    always_ff @(posedge clk) begin
        if (table_wr) begin
            entry_q[table_wr_index] <= table_wr_entry;
        end
    end

    // Parallel compare of every entry
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (entry_q[i].len <= interest.len)
                && (((entry_q[i].prefix ^ interest.prefix)
                     & len_mask(entry_q[i].len)) == '0);
        end
    end

    // Strictly longer replaces, so equal lengths keep the lower index
    always_comb begin
        found    = 1'b0;
        best_idx = '0;
        best_len = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (match[i] && (!found || entry_q[i].len > best_len)) begin
                found    = 1'b1;
                best_idx = IDX_W'(i);
                best_len = entry_q[i].len;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= interest_valid;
        end
    end

    // Winner capture, a miss zeroes the fields
    always_ff @(posedge clk) begin
        if (interest_valid) begin
            result.hit    <= found;
            result.len    <= found ? best_len : '0;
            result.prefix <= found ? entry_q[best_idx].prefix : '0;
            result.data   <= found ? entry_q[best_idx].data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/ndn_frame_encoder.sv ====
// ##############################
// Reply serializer onto tx, MSB first, line idles high
// No queue, a result arriving during a frame is lost and drop pulses
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_frame_encoder (
    input  wire                     clk,
    input  wire                     rst,
    input  ndn_pkg::lookup_result_t result,
    input  wire                     result_valid,
    output logic                    tx,
    output logic                    drop
);

    import ndn_pkg::*;

    // Whole reply including the start bit, top bit drives tx
    logic [HIT_FRAME_W-1:0] frame_q;

    // Cycles left in the current frame, zero when idle
    logic [FRAME_CNT_W-1:0] cnt_q;
    logic                   busy;

    logic [HDR_W-1:0]       hdr;
    logic [HIT_FRAME_W-1:0] frame_d;

    assign busy = (cnt_q != '0);

    // Build the frame to load
    always_comb begin
        if (result.hit) begin
            // Hit flag, data type, matched length
            hdr     = {1'b1, 1'b0, result.len};
            frame_d = {1'b0, hdr, result.prefix, result.data};
        end else begin
            // Miss header is all zero
            hdr     = '0;
            // Trailing ones so the line is already high after 9 bits
            frame_d = {1'b0, hdr, {(PREFIX_W + DATA_W){1'b1}}};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // All ones keeps tx high out of reset
            frame_q <= '1;
            cnt_q   <= '0;
            drop    <= 1'b0;
        end else begin
            // Any result during a frame is thrown away
            drop <= result_valid && busy;
            if (busy) begin
                // Shift in ones so idle follows the last bit
                frame_q <= {frame_q[HIT_FRAME_W-2:0], 1'b1};
                cnt_q   <= cnt_q - 1'b1;
            end else if (result_valid) begin
                // Start bit shows on tx the next cycle
                frame_q <= frame_d;
                cnt_q   <= result.hit ? FRAME_CNT_W'(HIT_FRAME_W)
                                      : FRAME_CNT_W'(MISS_FRAME_W);
            end
        end
    end

    // Serial out straight from the register
    assign tx = frame_q[HIT_FRAME_W-1];

endmodule

`default_nettype wire

// ==== src/ndn_link_top.sv ====
// ##############################
// Named-data link front end, decode -> table -> encode
// Last rx bit to reply start bit on tx is 3 clk
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_link_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rx,
    input  wire                      cs,
    input  wire                      table_wr,
    input  wire [ndn_pkg::IDX_W-1:0] table_wr_index,
    input  ndn_pkg::table_entry_t    table_wr_entry,
    output logic                     tx,
    output logic                     drop
);

    import ndn_pkg::*;

    // Decoder to table
    interest_t      interest;
    logic           interest_valid;

    // Table to encoder
    lookup_result_t result;
    logic           result_valid;

    ndn_frame_decoder u_decoder (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .cs             (cs),
        .interest       (interest),
        .interest_valid (interest_valid)
    );

    ndn_prefix_table u_table (
        .clk            (clk),
        .rst            (rst),
        .interest       (interest),
        .interest_valid (interest_valid),
        .table_wr       (table_wr),
        .table_wr_index (table_wr_index),
        .table_wr_entry (table_wr_entry),
        .result         (result),
        .result_valid   (result_valid)
    );

    ndn_frame_encoder u_encoder (
        .clk          (clk),
        .rst          (rst),
        .result       (result),
        .result_valid (result_valid),
        .tx           (tx),
        .drop         (drop)
    );

endmodule

`default_nettype wire

// ==== verification/ndn_link_chk.sv ====
// ##############################
// Port assertions bound into ndn_link_top
// A drop is only legal within one hit frame time of a start bit
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_link_chk (
    input wire clk,
    input wire rst,
    input wire tx,
    input wire drop
);

    import ndn_pkg::*;

    // Cycles since tx last showed a low bit, 255 means long idle
    logic [7:0] since_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            since_start <= 8'hff;
        end else if (!tx) begin
            since_start <= '0;
        end else if (since_start != 8'hff) begin
            since_start <= since_start + 8'd1;
        end
    end

    // Line idles high while reset holds
    a_tx_high_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> tx)
        else $error("tx was low during reset");

    // Encoder reports each lost result with a single pulse
    a_drop_one_cycle: assert property (@(posedge clk) disable iff (rst) drop |=> !drop)
        else $error("drop stayed high for two cycles");

    // A drop needs a reply frame in flight
    a_drop_in_frame: assert property (@(posedge clk) disable iff (rst)
        drop |-> int'(since_start) <= HIT_FRAME_W)
        else $error("drop pulsed while no reply frame was being sent");

endmodule

bind ndn_link_top ndn_link_chk chk (
    .clk  (clk),
    .rst  (rst),
    .tx   (tx),
    .drop (drop)
);

`default_nettype wire

// ==== verification/ndn_link_monitor.sv ====
// ##############################
// Watches tx and drop, compares each reply with the queued expectation
// Samples on the falling edge, replies must start within 200 cycles
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_link_monitor (
    input wire clk,
    input wire rst,
    input wire tx,
    input wire drop
);

    import ndn_pkg::*;

    lookup_result_t expect_q[$];
    logic           in_frame = 1'b0;
    int             frames = 0;
    int             drops = 0;
    int             errors = 0;

    // Queue the reply an interest should produce
    task automatic expect_reply(input lookup_result_t r);
        expect_q.push_back(r);
    endtask

    // Replies still owed, the one on the wire included
    function automatic int pending_replies();
        return expect_q.size() + (in_frame ? 1 : 0);
    endfunction

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && drop) begin
            drops++;
        end
    end

    initial begin : watch
        lookup_result_t   exp;
        logic [HDR_W-1:0] hdr;
        logic [HDR_W-1:0] exp_hdr;
        logic [PREFIX_W-1:0] pfx;
        logic [DATA_W-1:0] dat;
        int               wait_cycles;
        wait_cycles = 0;
        hdr = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                wait_cycles = 0;
            end else if (!tx) begin
                // Start bit, pull in header then payload on a hit
                in_frame = 1'b1;
                pfx = '0;
                dat = '0;
                repeat (HDR_W) begin
                    @(negedge clk);
                    hdr = {hdr[HDR_W-2:0], tx};
                end
                if (hdr[HDR_W-1]) begin
                    repeat (PREFIX_W) begin
                        @(negedge clk);
                        pfx = {pfx[PREFIX_W-2:0], tx};
                    end
                    repeat (DATA_W) begin
                        @(negedge clk);
                        dat = {dat[DATA_W-2:0], tx};
                    end
                end
                frames++;
                if (expect_q.size() == 0) begin
                    $display("Error at %0t: a reply frame arrived with no reply expected", $time);
                    errors++;
                end else begin
                    exp = expect_q.pop_front();
                    // Hit header is flag, data type, length; miss header is zero
                    exp_hdr = exp.hit ? {1'b1, 1'b0, exp.len} : '0;
                    compare_field("tx header", 64'(exp_hdr), 64'(hdr));
                    if (exp.hit && hdr[HDR_W-1]) begin
                        compare_field("tx prefix", exp.prefix, pfx);
                        compare_field("tx data", 64'(exp.data), 64'(dat));
                    end
                end
                in_frame = 1'b0;
                wait_cycles = 0;
            end else if (expect_q.size() != 0) begin
                wait_cycles++;
                if (wait_cycles >= 200) begin
                    $display("Error at %0t: no reply frame within 200 cycles", $time);
                    errors++;
                    void'(expect_q.pop_front());
                    wait_cycles = 0;
                end
            end else begin
                wait_cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/ndn_link_tb.sv ====
// ##############################
// Link testbench, inputs change 1 ns after the rising edge
// Table model mirrors every write made through load_entry
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ndn_link_tb;

    import ndn_pkg::*;

    logic             clk;
    logic             rst;
    logic             rx;
    logic             cs;
    logic             table_wr;
    logic [IDX_W-1:0] table_wr_index;
    table_entry_t     table_wr_entry;
    logic             tx;
    logic             drop;

    table_entry_t model [NUM_ENTRIES];
    logic [31:0]  rng_state = 32'hf485;
    int           tb_errors = 0;
    int           errors_at_start = 0;
    int           drops_at_start = 0;

    ndn_link_top dut (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .cs             (cs),
        .table_wr       (table_wr),
        .table_wr_index (table_wr_index),
        .table_wr_entry (table_wr_entry),
        .tx             (tx),
        .drop           (drop)
    );

    ndn_link_monitor mon (
        .clk  (clk),
        .rst  (rst),
        .tx   (tx),
        .drop (drop)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Xorshift32 step on the shared state
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Top len bits of both names agree, len 0 always agrees
    function automatic logic top_bits_equal(input logic [PREFIX_W-1:0] x,
                                            input logic [PREFIX_W-1:0] y,
                                            input logic [LEN_W-1:0] len);
        for (int b = 0; b < int'(len); b++) begin
            if (x[PREFIX_W-1-b] !== y[PREFIX_W-1-b]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Longest valid entry not longer than the interest, lowest index on a tie
    function automatic lookup_result_t ref_lookup(input logic [LEN_W-1:0] len,
                                                  input logic [PREFIX_W-1:0] pfx);
        lookup_result_t r;
        int             best;
        best = -1;
        r = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (model[i].valid && model[i].len <= len
                    && top_bits_equal(model[i].prefix, pfx, model[i].len)) begin
                if (best < 0 || model[i].len > model[best].len) begin
                    best = i;
                end
            end
        end
        if (best >= 0) begin
            r.hit    = 1'b1;
            r.len    = model[best].len;
            r.prefix = model[best].prefix;
            r.data   = model[best].data;
        end
        return r;
    endfunction

    task automatic load_entry(input logic [IDX_W-1:0] idx, input logic valid,
                              input logic [LEN_W-1:0] len, input logic [PREFIX_W-1:0] pfx,
                              input logic [DATA_W-1:0] data);
        table_entry_t e;
        e.valid = valid;
        e.len = len;
        e.prefix = pfx;
        e.data = data;
        @(posedge clk);
        #1;
        table_wr = 1'b1;
        table_wr_index = idx;
        table_wr_entry = e;
        @(posedge clk);
        #1;
        table_wr = 1'b0;
        model[idx] = e;
    endtask

    // Start bit, filler, type, length, prefix; cs rises early when abort_at is reached
    task automatic send_frame(input logic type_bit, input logic [LEN_W-1:0] len,
                              input logic [PREFIX_W-1:0] pfx, input int abort_at);
        logic [HDR_W+PREFIX_W:0] bits;
        bits = {1'b0, 1'b0, type_bit, len, pfx};
        @(posedge clk);
        #1;
        for (int i = 0; i <= HDR_W + PREFIX_W; i++) begin
            if (i == abort_at) begin
                break;
            end
            cs = 1'b0;
            rx = bits[HDR_W + PREFIX_W - i];
            @(posedge clk);
            #1;
        end
        cs = 1'b1;
        rx = 1'b1;
    endtask

    // Block until every queued reply is seen or 400 cycles pass
    task automatic wait_replies();
        int n;
        n = 0;
        while (mon.pending_replies() != 0 && n < 400) begin
            @(posedge clk);
            n++;
        end
        if (n >= 400) begin
            $display("Error at %0t: timed out waiting for expected replies", $time);
            tb_errors++;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic run_interest(input logic [LEN_W-1:0] len, input logic [PREFIX_W-1:0] pfx);
        mon.expect_reply(ref_lookup(len, pfx));
        send_frame(1'b1, len, pfx, -1);
        wait_replies();
    endtask

    task automatic finish_test(input string name, input int exp_drops);
        int errs;
        int drops_seen;
        drops_seen = mon.drops - drops_at_start;
        if (drops_seen != exp_drops) begin
            $display("CHECK FAILED at %0t: drop pulses expected %0d, got %0d",
                     $time, exp_drops, drops_seen);
            tb_errors++;
        end
        errs = mon.errors + tb_errors - errors_at_start;
        $display("Test %s finished with %0d error(s)", name, errs);
        errors_at_start = mon.errors + tb_errors;
        drops_at_start = mon.drops;
    endtask

    // Hard stop in case the sequence stalls
    initial begin : watchdog
        for (int n = 0; n < 60000; n++) begin
            @(posedge clk);
        end
        $display("Simulation ran out of time before the test sequence ended");
        $display("Checks failed");
        $finish;
    end

    initial begin : sequence_main
        logic [31:0] r;
        int          total;
        rst = 1'b1;
        rx = 1'b1;
        cs = 1'b1;
        table_wr = 1'b0;
        table_wr_index = '0;
        table_wr_entry = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Nested prefixes of length 0, 8, 16 and 24
        load_entry(2'd0, 1'b1, 6'd0, 64'h0, 32'h0000_00a0);
        load_entry(2'd1, 1'b1, 6'd8, 64'ha500_0000_0000_0000, 32'h1111_1111);
        load_entry(2'd2, 1'b1, 6'd16, 64'ha53c_0000_0000_0000, 32'h2222_2222);
        load_entry(2'd3, 1'b1, 6'd24, 64'ha53c_7700_0000_0000, 32'h3333_3333);
        run_interest(6'd32, 64'ha53c_77ff_0123_4567);
        run_interest(6'd32, 64'ha53c_1234_0000_0000);
        run_interest(6'd32, 64'ha599_0000_0000_0000);
        run_interest(6'd32, 64'h1234_5678_9abc_def0);
        finish_test("longest_match", 0);

        // Catch-all removed, then an interest shorter than every entry
        load_entry(2'd0, 1'b0, 6'd0, 64'h0, 32'h0);
        run_interest(6'd32, 64'h1234_5678_9abc_def0);
        run_interest(6'd4, 64'ha53c_7700_0000_0000);
        finish_test("miss", 0);

        // Data frame is swallowed, the monitor flags any reply
        send_frame(1'b0, 6'd32, 64'ha53c_77ff_0000_0000, -1);
        repeat (200) @(posedge clk);
        run_interest(6'd20, 64'ha53c_0000_0000_0000);
        finish_test("data_frame", 0);

        // Deselect partway through the prefix
        send_frame(1'b1, 6'd32, 64'ha53c_77ff_0000_0000, 30);
        repeat (100) @(posedge clk);
        run_interest(6'd32, 64'ha53c_7711_0000_0000);
        finish_test("abort", 0);

        // Second interest lands while the first hit reply is on tx
        mon.expect_reply(ref_lookup(6'd32, 64'ha53c_77aa_0000_0000));
        send_frame(1'b1, 6'd32, 64'ha53c_77aa_0000_0000, -1);
        send_frame(1'b1, 6'd32, 64'ha500_0000_0000_0000, -1);
        wait_replies();
        repeat (200) @(posedge clk);
        finish_test("drop", 1);

        // Random table with a shared top, interests one bit flip away from an entry
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            r = next_random();
            load_entry(IDX_W'(k), r[31] | r[30], r[21:16],
                       {16'hc0de, next_random(), r[15:0]}, next_random());
        end
        for (int t = 0; t < 20; t++) begin
            r = next_random();
            run_interest(r[13:8], model[r[17:16]].prefix ^ (64'h1 << r[5:0]));
        end
        finish_test("random", 0);

        total = mon.errors + tb_errors;
        $display("Replies %0d, drops %0d, errors %0d", mon.frames, mon.drops, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/ndn_pkg.sv
src/ndn_frame_decoder.sv
src/ndn_prefix_table.sv
src/ndn_frame_encoder.sv
src/ndn_link_top.sv
verification/ndn_link_chk.sv
verification/ndn_link_monitor.sv
verification/ndn_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the link testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -j 0 --top-module ndn_link_tb \
    -f list.f -o ndn_link_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/ndn_link_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
